/* design/soc_pkg.sv */
package soc_pkg;

   // ------------------------------------------------------------------
   // Memory geometry
   // ------------------------------------------------------------------
   localparam int ADDR_W    = 6;
   localparam int MEM_DEPTH = 64;

   // Command opcodes, 00 and 11 are illegal
   localparam logic [1:0] OP_WRITE = 2'b01;
   localparam logic [1:0] OP_READ  = 2'b10;

   // ------------------------------------------------------------------
   // Link payloads
   // ------------------------------------------------------------------
   typedef struct packed {
      logic [7:0] data;
   } uart_byte_t;

   // Write view of a command frame
   typedef struct packed {
      logic [1:0]        op;
      logic [ADDR_W-1:0] addr;
      logic [7:0]        data;   // Byte to store
   } cmd_wr_t;

   // Read view of a command frame
   typedef struct packed {
      logic [1:0]        op;
      logic [ADDR_W-1:0] addr;
      logic [7:0]        count;  // Bytes returned minus one
   } cmd_rd_t;

   // First received byte sits in the upper half
   typedef union packed {
      cmd_wr_t wr;
      cmd_rd_t rd;
   } cmd_frame_u;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                rxd_i,
   output logic                rx_valid_o,
   output soc_pkg::uart_byte_t rx_byte_o,
   input  logic                rx_ready_i
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t        state;
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_cnt;
   logic             rxd_meta, rxd_sync, rxd_prev;
   logic [7:0]       shift_q;
   logic             bit_end;

   assign bit_end = (clk_cnt == FULL_CNT);

   // Line synchroniser, idle level is high
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd_i;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state      <= RX_IDLE;
         clk_cnt    <= '0;
         bit_cnt    <= '0;
         rx_valid_o <= 1'b0;
      end else begin
         if (rx_valid_o && rx_ready_i) rx_valid_o <= 1'b0;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (rxd_prev && !rxd_sync) state <= RX_START;  // Falling edge
            end
            RX_START: begin
               if (clk_cnt == HALF_CNT) begin
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= rxd_sync ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  clk_cnt <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) state <= RX_STOP;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: begin
               if (bit_end) begin
                  state <= RX_IDLE;
                  if (rxd_sync) rx_valid_o <= 1'b1;  // Framing error drops byte
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // LSB first into the top of the shifter
   always_ff @(posedge clk_i) begin
      if (state == RX_DATA && bit_end) shift_q <= {rxd_sync, shift_q[7:1]};
      if (state == RX_STOP && bit_end && rxd_sync) rx_byte_o.data <= shift_q;
   end

endmodule

/* design/cmd_engine.sv */
`timescale 1ns/1ps

module cmd_engine (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                rx_valid_i,
   input  soc_pkg::uart_byte_t rx_byte_i,
   output logic                rx_ready_o,
   output logic                tx_valid_o,
   output soc_pkg::uart_byte_t tx_byte_o,
   input  logic                tx_ready_i,
   output logic                trap_o
);

   import soc_pkg::*;

   logic [7:0]        mem [MEM_DEPTH];
   cmd_frame_u        frame_q;     // Upper half holds the first byte
   cmd_frame_u        frame_d;
   logic              second_q;    // Next byte completes a frame
   logic              burst_q;
   logic [ADDR_W-1:0] burst_addr;  // Wraps at the memory size
   logic [7:0]        remain_q;
   logic              rx_fire, tx_fire;
   logic              frame_done;
   logic              read_go;

   // ------------------------------------------------------------------
   // Handshakes and frame decode
   // ------------------------------------------------------------------
   assign rx_ready_o = !burst_q;  // Hold off input during a burst
   assign rx_fire    = rx_valid_i && rx_ready_o;
   assign tx_fire    = tx_valid_o && tx_ready_i;

   assign frame_d    = {frame_q.wr.op, frame_q.wr.addr, rx_byte_i.data};
   assign frame_done = rx_fire && second_q && !trap_o;
   assign read_go    = frame_done && (frame_d.rd.op == OP_READ);

   // ------------------------------------------------------------------
   // Control and memory
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         second_q   <= 1'b0;
         burst_q    <= 1'b0;
         burst_addr <= '0;
         remain_q   <= '0;
         tx_valid_o <= 1'b0;
         trap_o     <= 1'b0;
         for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else begin
         if (rx_fire && !trap_o) second_q <= !second_q;  // Trapped engine drops bytes

         if (frame_done) begin
            case (frame_d.wr.op)
               OP_WRITE: begin
                  mem[frame_d.wr.addr] <= frame_d.wr.data;
               end
               OP_READ: begin
                  burst_q    <= 1'b1;
                  tx_valid_o <= 1'b1;
                  burst_addr <= frame_d.rd.addr + 1'b1;  // First byte loaded below
                  remain_q   <= frame_d.rd.count;
               end
               default: begin
                  trap_o <= 1'b1;  // Sticky until reset
               end
            endcase
         end

         // Burst sequencing, one byte per tx handshake
         if (tx_fire) begin
            if (remain_q == '0) begin
               tx_valid_o <= 1'b0;
               burst_q    <= 1'b0;
            end else begin
               burst_addr <= burst_addr + 1'b1;
               remain_q   <= remain_q - 1'b1;
            end
         end
      end
   end

   // ------------------------------------------------------------------
   // Payload registers
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rx_fire && !second_q) frame_q <= {rx_byte_i.data, 8'h00};

      if (read_go) begin
         tx_byte_o.data <= mem[frame_d.rd.addr];
      end else if (tx_fire && remain_q != '0) begin
         tx_byte_o.data <= mem[burst_addr];  // Next byte of the burst
      end
   end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                tx_valid_i,
   input  soc_pkg::uart_byte_t tx_byte_i,
   output logic                tx_ready_o,
   output logic                txd_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

   logic             busy_q;
   logic [CNT_W-1:0] clk_cnt;
   logic [3:0]       bit_cnt;   // 0 is start, 9 is stop
   logic [9:0]       frame_q;
   logic             tx_fire;
   logic             bit_end;

   assign tx_ready_o = !busy_q;
   assign tx_fire    = tx_valid_i && tx_ready_o;
   assign bit_end    = busy_q && (clk_cnt == FULL_CNT);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q  <= 1'b0;
         clk_cnt <= '0;
         bit_cnt <= '0;
         txd_o   <= 1'b1;  // Line idles high
      end else if (tx_fire) begin
         busy_q  <= 1'b1;
         clk_cnt <= '0;
         bit_cnt <= '0;
         txd_o   <= 1'b0;  // Start bit
      end else if (bit_end) begin
         clk_cnt <= '0;
         if (bit_cnt == 4'd9) begin
            busy_q <= 1'b0;
            txd_o  <= 1'b1;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
            txd_o   <= frame_q[1];
         end
      end else if (busy_q) begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   // Stop, data LSB first, start
   always_ff @(posedge clk_i) begin
      if (tx_fire) begin
         frame_q <= {1'b1, tx_byte_i.data, 1'b0};
      end else if (bit_end) begin
         frame_q <= {1'b1, frame_q[9:1]};
      end
   end

endmodule

/* design/soc_uart_top.sv */
`timescale 1ns/1ps

module soc_uart_top #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic uart_rxd_i,
   output logic uart_txd_o,
   output logic trap_o
);

   import soc_pkg::*;

   logic       rst_meta;
   logic       rst_n_sync;
   logic       rx_valid, rx_ready;
   logic       tx_valid, tx_ready;
   uart_byte_t rx_byte;
   uart_byte_t tx_byte;

   // ------------------------------------------------------------------
   // Reset synchroniser, asserts at once and releases on the 2nd edge
   // ------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rst_meta   <= 1'b0;
         rst_n_sync <= 1'b0;
      end else begin
         rst_meta   <= 1'b1;
         rst_n_sync <= rst_meta;
      end
   end

   // ------------------------------------------------------------------
   // Serial in, command engine, serial out
   // ------------------------------------------------------------------
   uart_rx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_rx_i (
      .clk_i     (clk_i),
      .arst_n_i  (rst_n_sync),
      .rxd_i     (uart_rxd_i),
      .rx_valid_o(rx_valid),
      .rx_byte_o (rx_byte),
      .rx_ready_i(rx_ready)
   );

   cmd_engine cmd_engine_i (
      .clk_i     (clk_i),
      .arst_n_i  (rst_n_sync),
      .rx_valid_i(rx_valid),
      .rx_byte_i (rx_byte),
      .rx_ready_o(rx_ready),
      .tx_valid_o(tx_valid),
      .tx_byte_o (tx_byte),
      .tx_ready_i(tx_ready),
      .trap_o    (trap_o)
   );

   uart_tx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_tx_i (
      .clk_i     (clk_i),
      .arst_n_i  (rst_n_sync),
      .tx_valid_i(tx_valid),
      .tx_byte_i (tx_byte),
      .tx_ready_o(tx_ready),
      .txd_o     (uart_txd_o)
   );

endmodule

/* test/soc_uart_assertions.sv */
`timescale 1ns/1ps

module soc_uart_assertions (
   input logic                clk_i,
   input logic                rst_n_i,
   input logic                rx_valid_i,
   input logic                rx_ready_i,
   input soc_pkg::uart_byte_t rx_byte_i,
   input logic                tx_valid_i,
   input logic                tx_ready_i,
   input soc_pkg::uart_byte_t tx_byte_i,
   input logic                txd_i,
   input logic                trap_i
);

   // ------------------------------------------------------------------
   // Link protocol
   // ------------------------------------------------------------------
   a_rx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rx_valid_i && !rx_ready_i |=> rx_valid_i && $stable(rx_byte_i))
      else $error("rx_valid dropped or rx_byte changed while stalled");

   a_tx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_byte_i))
      else $error("tx_valid dropped or tx_byte changed while stalled");

   a_no_rx_in_burst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_valid_i |-> !rx_ready_i)
      else $error("rx_ready high while a reply byte is pending");

   // ------------------------------------------------------------------
   // Line level and trap
   // ------------------------------------------------------------------
   // Line is high once reset has been seen for a full cycle
   a_txd_reset: assert property (@(posedge clk_i)
      !rst_n_i && $past(!rst_n_i) |-> txd_i)
      else $error("txd low during reset");

   a_trap_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      trap_i |=> trap_i)
      else $error("trap fell while out of reset");

endmodule

bind soc_uart_top soc_uart_assertions soc_uart_assertions_i (
   .clk_i     (clk_i),
   .rst_n_i   (rst_n_sync),
   .rx_valid_i(rx_valid),
   .rx_ready_i(rx_ready),
   .rx_byte_i (rx_byte),
   .tx_valid_i(tx_valid),
   .tx_ready_i(tx_ready),
   .tx_byte_i (tx_byte),
   .txd_i     (uart_txd_o),
   .trap_i    (trap_o)
);

/* test/tb_soc_uart.sv */
`timescale 1ns/1ps

module tb_soc_uart;

   import soc_pkg::*;

   localparam int CLKS_PER_BIT = 8;
   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int DRV_DLY      = 2;
   localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;  // One 8N1 character
   localparam int ST_OK        = 0;
   localparam int ST_NO_START  = 1;
   localparam int ST_BAD_STOP  = 2;
   localparam logic [127:0] COMMENT_TOK = 128'h23;  // Lone # token
   localparam logic [127:0] IDLE_NAME   = {48'd0, "reset_idle"};

   logic clk_i, arst_n_i, uart_rxd_i, uart_txd_o, trap_o;

   // Trace operations and the flat list of expected reply bytes
   logic [127:0] name_q[$];
   logic [7:0]   op_q[$], a_q[$], b_q[$], exp_q[$];
   int           base_q[$];
   int           n_ops = 0;
   int           test_errs = 0, total_errs = 0, n_pass = 0, n_fail = 0;
   logic         trap_exp = 1'b0;

   soc_uart_top #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) soc_uart_top_i (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .uart_rxd_i(uart_rxd_i),
      .uart_txd_o(uart_txd_o),
      .trap_o    (trap_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // ------------------------------------------------------------------
   // Trace reading
   // ------------------------------------------------------------------
   task automatic load_trace(input int fd);
      logic [127:0]    tok;
      logic [8*96-1:0] rest;
      logic [7:0]      op, a, b, v;
      int              code;
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok == COMMENT_TOK) begin
            code = $fgets(rest, fd);
         end else begin
            code = $fscanf(fd, "%s %h %h", op, a, b);
            assert (code == 3) else begin
               $display("A trace line of %0s is incomplete", tok);
               total_errs++;
            end
            name_q.push_back(tok);
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
            base_q.push_back(exp_q.size());
            if (op == "R") begin
               for (int k = 0; k <= int'(b); k++) begin
                  code = $fscanf(fd, "%h", v);
                  assert (code == 1) else begin
                     $display("Expected reply byte %0d of %0s is missing", k, tok);
                     total_errs++;
                  end
                  exp_q.push_back(v);
               end
            end
         end
      end
      n_ops = name_q.size();
   endtask

   // ------------------------------------------------------------------
   // Serial line
   // ------------------------------------------------------------------
   task automatic send_byte(input logic [7:0] value);
      logic [9:0] frame;
      frame = {1'b1, value, 1'b0};  // Start bit goes out first
      repeat (10) begin
         @(posedge clk_i);
         #DRV_DLY uart_rxd_i = frame[0];
         frame = {1'b1, frame[9:1]};
         repeat (CLKS_PER_BIT - 1) @(posedge clk_i);
      end
   endtask

   task automatic receive_byte(output logic [7:0] value, output int status);
      int waited;
      waited = 0;
      value  = '0;
      status = ST_OK;
      @(negedge clk_i);
      while (uart_txd_o !== 1'b0 && waited < 2 * FRAME_CLKS) begin
         @(negedge clk_i);
         waited++;
      end
      if (uart_txd_o !== 1'b0) begin
         status = ST_NO_START;
      end else begin
         repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk_i);  // Middle of start bit
         repeat (8) begin
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            value = {uart_txd_o, value[7:1]};  // LSB first
         end
         repeat (CLKS_PER_BIT) @(negedge clk_i);
         if (uart_txd_o !== 1'b1) status = ST_BAD_STOP;
      end
   endtask

   task automatic watch_line(input int n_clks, output logic quiet, output logic trapped);
      quiet   = 1'b1;
      trapped = 1'b0;
      repeat (n_clks) begin
         @(negedge clk_i);
         if (uart_txd_o !== 1'b1) quiet = 1'b0;
         if (trap_o === 1'b1) trapped = 1'b1;
      end
   endtask

   // ------------------------------------------------------------------
   // Operations and per-test results
   // ------------------------------------------------------------------
   task automatic run_op(input int idx);
      logic [7:0] op, a, b, got;
      int         status;
      logic       quiet, trapped;
      op     = op_q[idx];
      a      = a_q[idx];
      b      = b_q[idx];
      status = ST_OK;
      if (op == "W") begin
         send_byte({OP_WRITE, a[ADDR_W-1:0]});
         send_byte(b);
      end else if (op == "R") begin
         send_byte({OP_READ, a[ADDR_W-1:0]});
         send_byte(b);
         if (trap_exp) begin
            watch_line(2 * FRAME_CLKS, quiet, trapped);
            assert (quiet) else begin
               $display("A frame was sent for the read at 0x%02h after the trap", a);
               test_errs++;
            end
         end else begin
            for (int k = 0; k <= int'(b) && status == ST_OK; k++) begin
               receive_byte(got, status);
               assert (status != ST_NO_START) else begin
                  $display("No reply byte %0d for the read at 0x%02h", k, a);
                  test_errs++;
               end
               assert (status != ST_BAD_STOP) else begin
                  $display("Stop bit of reply byte %0d was missing", k);
                  test_errs++;
               end
               if (status == ST_OK) begin
                  assert (got == exp_q[base_q[idx] + k]) else begin
                     $display("Error uart_txd_o byte expected 0x%02h got 0x%02h",
                              exp_q[base_q[idx] + k], got);
                     test_errs++;
                  end
               end
            end
            watch_line(12 * CLKS_PER_BIT, quiet, trapped);
            assert (quiet) else begin
               $display("More bytes than requested for the read at 0x%02h", a);
               test_errs++;
            end
         end
      end else begin
         send_byte(a);
         send_byte(b);
         watch_line(2 * FRAME_CLKS, quiet, trapped);
         assert (trapped) else begin
            $display("trap_o did not rise after the illegal opcode");
            test_errs++;
         end
         assert (quiet) else begin
            $display("A frame was sent after the illegal opcode");
            test_errs++;
         end
         trap_exp = 1'b1;
      end
      assert (trap_o === trap_exp) else begin
         if (trap_exp) $display("trap_o fell after the trap was raised");
         else $display("trap_o rose without an illegal opcode");
         test_errs++;
      end
   endtask

   task automatic finish_test(input logic [127:0] name);
      if (test_errs == 0) begin
         n_pass++;
         $display("%0s: pass", name);
      end else begin
         n_fail++;
         $display("%0s: FAIL with %0d errors", name, test_errs);
      end
      total_errs += test_errs;
      test_errs   = 0;
   endtask

   // ------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------
   initial begin
      int   fd;
      logic quiet, trapped;
      arst_n_i   = 1'b1;
      uart_rxd_i = 1'b1;
      fd = $fopen("test/soc_uart_trace.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the trace file test/soc_uart_trace.txt");
         $display("test failed");
         $finish;
      end else begin
         load_trace(fd);
         $fclose(fd);
         #1 arst_n_i = 1'b0;  // Falling edge ahead of the first clock
         repeat (RESET_CYCLES) @(posedge clk_i);
         #DRV_DLY arst_n_i = 1'b1;

         watch_line(100, quiet, trapped);
         assert (quiet) else begin
            $display("Error uart_txd_o expected 0x1 got 0x0");
            test_errs++;
         end
         assert (!trapped) else begin
            $display("trap_o rose while the engine was idle");
            test_errs++;
         end
         finish_test(IDLE_NAME);

         assert (n_ops > 0) else begin
            $display("The trace file holds no operations");
            total_errs++;
         end
         for (int i = 0; i < n_ops; i++) begin
            if (i > 0 && name_q[i] != name_q[i - 1]) finish_test(name_q[i - 1]);
            run_op(i);
         end
         if (n_ops > 0) finish_test(name_q[n_ops - 1]);

         $display("Summary: %0d tests pass, %0d tests fail, %0d errors",
                  n_pass, n_fail, total_errs);
         if (n_fail == 0 && total_errs == 0) begin
            $display("test passed");
         end else begin
            $display("test failed");
         end
         $finish;
      end
   end

   // Run limit scales with the trace length
   initial begin
      int limit_ns;
      wait (n_ops > 0);
      limit_ns = n_ops * 40 * CLKS_PER_BIT * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
      #(limit_ns);
      $display("Watchdog expired after %0d ns with the DUT not answering", limit_ns);
      $display("test failed");
      $finish;
   end

endmodule

/* project.f */
design/soc_pkg.sv
design/uart_rx.sv
design/cmd_engine.sv
design/uart_tx.sv
design/soc_uart_top.sv
test/soc_uart_assertions.sv
test/tb_soc_uart.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_soc_uart --Mdir obj_dir

output=$(./obj_dir/Vtb_soc_uart 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "test passed"; then
   exit 0
else
   exit 1
fi

/* test/soc_uart_trace.txt */
# name op a b [expected reply bytes] with all values in hex
# W addr data | R addr count byte0..byteN | X byte0 byte1
single    W 05 a5
single    R 05 00 a5
burst     W 10 11
burst     W 11 22
burst     W 13 44
burst     W 14 55
burst     R 10 04 11 22 00 44 55
burst     R 30 01 00 00
wrap      W 3e 5a
wrap      W 3f 6b
wrap      W 00 7c
wrap      W 01 8d
wrap      R 3e 03 5a 6b 7c 8d
overwrite W 20 c3
overwrite R 20 00 c3
overwrite W 20 3c
overwrite R 20 00 3c
# Op 11 in the first byte raises the trap
# A read after the trap gets no reply so its listed byte goes unused
illegal   X c5 00
illegal   R 05 00 a5
